//--- source/rob_cfg.svh
// Reorder buffer configuration with buffer depth and channel field widths
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// Number of beat slots in the reorder buffer
// Must be a power of two since slot pointers wrap by overflow
`define ROB_SIZE 16

// Request id width
`define ID_BITS 4

// Burst length field, beats minus one
`define LEN_BITS 2

// Response data width
`define DATA_BITS 32

// Destination select width on the network side
`define DEST_BITS 2

`endif

//--- source/noc_pkg.sv
// Network channel types shared by the request and response sides
`include "rob_cfg.svh"

package noc_pkg;

  // Request fields
  typedef logic [`ID_BITS-1:0]   ax_id_t;
  typedef logic [`LEN_BITS-1:0]  ax_len_t;
  typedef logic [`DEST_BITS-1:0] dest_t;

  // Response payload word
  typedef logic [`DATA_BITS-1:0] rsp_data_t;

  // One response beat as it travels through the network
  // id + data + last gives 37 bits with the default widths
  typedef struct packed {
    ax_id_t    id;
    rsp_data_t data;
    logic      last;
  } rsp_chan_t;

endpackage

//--- source/rob_pkg.sv
// Reorder buffer bookkeeping types for slot indices and slot counts
`include "rob_cfg.svh"

package rob_pkg;

  // Bits needed to address one slot
  localparam int unsigned ROB_IDX_BITS = $clog2(`ROB_SIZE);

  // Slot index that also serves as the base tag carried by a request
  typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

  // Slot count is one bit wider so a completely free buffer fits
  typedef logic [ROB_IDX_BITS:0] rob_cnt_t;

endpackage

//--- source/rob_alloc.sv
// Request side of the reorder buffer that reserves contiguous slots and gates the handshake
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_alloc
  import noc_pkg::*;
  import rob_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  // Request from the initiator
  input  logic     ax_valid_i,
  output logic     ax_ready_o,
  input  ax_len_t  ax_len_i,
  input  ax_id_t   ax_id_i,
  input  dest_t    ax_dest_i,
  // Request towards the network
  output logic     ax_valid_o,
  input  logic     ax_ready_i,
  output rob_idx_t ax_rob_idx_o,
  // Allocation strobe for the slot store
  output logic     alloc_valid_o,
  // One slot returned by the release stage
  input  logic     free_i
);

  rob_idx_t tail_q;
  rob_cnt_t free_cnt_q;
  rob_cnt_t free_cnt_d;
  rob_cnt_t burst_beats;
  logic     space_ok;
  logic     accept;

  // Slots needed by this request
  assign burst_beats = rob_cnt_t'(ax_len_i) + rob_cnt_t'(1);

  // The whole burst must fit before the request may leave
  assign space_ok = (free_cnt_q >= burst_beats);

  assign ax_valid_o = ax_valid_i && space_ok;
  assign ax_ready_o = ax_ready_i && space_ok;
  assign accept     = ax_valid_i && ax_ready_i && space_ok;

  // Base slot travels with the request and comes back on every response beat
  assign ax_rob_idx_o  = tail_q;
  assign alloc_valid_o = accept;

  // Tail moves past the reserved block and wraps by overflow
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tail_q <= '0;
    end else if (accept) begin
      tail_q <= tail_q + rob_idx_t'(burst_beats);
    end
  end

  // Reservation takes a block and each release gives back one slot
  always_comb begin
    free_cnt_d = free_cnt_q;
    if (accept) begin
      free_cnt_d = free_cnt_d - burst_beats;
    end
    if (free_i) begin
      free_cnt_d = free_cnt_d + rob_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      free_cnt_q <= rob_cnt_t'(`ROB_SIZE);
    end else begin
      free_cnt_q <= free_cnt_d;
    end
  end

  // More releases than reservations would mean a slot was freed twice
  a_free_cnt_bound: assert property (
    @(posedge clk_i) disable iff (reset_i)
    free_cnt_q <= rob_cnt_t'(`ROB_SIZE)
  ) else $error("free slot count above buffer size");

  // A request waiting on the network holds its fields
  a_req_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ax_valid_o && !ax_ready_i |=> ax_valid_i && $stable({ax_id_i, ax_len_i, ax_dest_i})
  ) else $error("request changed while waiting for ax_ready_i");

endmodule

//--- source/rob_store.sv
// Slot memory of the reorder buffer that is filled by response beats tagged with their base slot
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_store
  import noc_pkg::*;
  import rob_pkg::*;
#(
  // Beat stored per slot
  parameter type payload_t = rsp_chan_t
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // Base slot of a request just accepted by the allocator
  input  logic     alloc_valid_i,
  input  rob_idx_t alloc_idx_i,
  // Response beats from the network
  input  logic     rsp_valid_i,
  output logic     rsp_ready_o,
  input  payload_t rsp_i,
  input  rob_idx_t rsp_rob_idx_i,
  input  logic     rsp_last_i,
  // Head slot towards the release stage
  input  rob_idx_t head_idx_i,
  input  logic     free_i,
  output logic     head_valid_o,
  output payload_t head_beat_o
);

  payload_t             slot_mem_q [`ROB_SIZE];
  logic [`ROB_SIZE-1:0] slot_valid_q;
  rob_idx_t             wr_off_q;
  rob_idx_t             wr_idx;
  logic                 wr_en;

  // Beats of one burst arrive back to back and fill consecutive slots
  assign wr_idx = rsp_rob_idx_i + wr_off_q;

  // Slot is free unless it still holds an unreleased beat
  assign rsp_ready_o = !slot_valid_q[wr_idx];
  assign wr_en       = rsp_valid_i && rsp_ready_o;

  // Offset within the current burst returns to zero after the last beat
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_off_q <= '0;
    end else if (wr_en) begin
      if (rsp_last_i) begin
        wr_off_q <= '0;
      end else begin
        wr_off_q <= wr_off_q + rob_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      slot_mem_q[wr_idx] <= rsp_i;
    end
  end

  // Head slot and write slot never coincide since head valid blocks the write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= '0;
    end else begin
      if (free_i) begin
        slot_valid_q[head_idx_i] <= 1'b0;
      end
      if (wr_en) begin
        slot_valid_q[wr_idx] <= 1'b1;
      end
    end
  end

  assign head_valid_o = slot_valid_q[head_idx_i];
  assign head_beat_o  = slot_mem_q[head_idx_i];

  // The network only answers into reserved slots, which are empty by then
  a_rsp_slot_free: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> !slot_valid_q[wr_idx]
  ) else $error("response beat addresses an occupied slot");

  // Allocator must only hand out slots already drained by the release stage
  a_alloc_slot_free: assert property (
    @(posedge clk_i) disable iff (reset_i)
    alloc_valid_i |-> !slot_valid_q[alloc_idx_i]
  ) else $error("base slot reserved while still occupied");

endmodule

//--- source/rob_release.sv
// Release stage of the reorder buffer that drains the head slot in request order
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_release
  import noc_pkg::*;
  import rob_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // Head slot from the store
  input  logic      head_valid_i,
  input  rsp_chan_t head_beat_i,
  output rob_idx_t  head_idx_o,
  output logic      free_o,
  // Ordered response output
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output rsp_chan_t rsp_o
);

  rob_idx_t  head_q;
  logic      out_valid_q;
  rsp_chan_t out_q;
  logic      load;

  // Output stage takes a new beat when empty or draining this cycle
  assign load = head_valid_i && (!out_valid_q || rsp_ready_i);

  // Slot is released as soon as its beat moves into the output stage
  assign free_o     = load;
  assign head_idx_o = head_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q <= '0;
    end else if (load) begin
      head_q <= head_q + rob_idx_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_q <= head_beat_i;
    end
  end

  assign rsp_valid_o = out_valid_q;
  assign rsp_o       = out_q;

  // Stalled output keeps its beat until taken
  a_rsp_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
  ) else $error("rsp_o changed while stalled");

endmodule

//--- source/rob_wrapper.sv
// Response reorder buffer top that ties allocator, slot store and release stage together
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_wrapper
  import noc_pkg::*;
  import rob_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // Request in
  input  logic      ax_valid_i,
  output logic      ax_ready_o,
  input  ax_len_t   ax_len_i,
  input  ax_id_t    ax_id_i,
  input  dest_t     ax_dest_i,
  // Request out to the network
  output logic      ax_valid_o,
  input  logic      ax_ready_i,
  output rob_idx_t  ax_rob_idx_o,
  // Out of order response in from the network
  input  logic      rsp_valid_i,
  output logic      rsp_ready_o,
  input  rsp_chan_t rsp_i,
  input  rob_idx_t  rsp_rob_idx_i,
  input  logic      rsp_last_i,
  // Response out in request order
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output rsp_chan_t rsp_o
);

  logic      alloc_valid;
  rob_idx_t  head_idx;
  logic      head_valid;
  rsp_chan_t head_beat;
  logic      free;

  rob_alloc u_rob_alloc (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .ax_valid_i    ( ax_valid_i   ),
    .ax_ready_o    ( ax_ready_o   ),
    .ax_len_i      ( ax_len_i     ),
    .ax_id_i       ( ax_id_i      ),
    .ax_dest_i     ( ax_dest_i    ),
    .ax_valid_o    ( ax_valid_o   ),
    .ax_ready_i    ( ax_ready_i   ),
    .ax_rob_idx_o  ( ax_rob_idx_o ),
    .alloc_valid_o ( alloc_valid  ),
    .free_i        ( free         )
  );

  // Full response beats kept per slot
  rob_store #(
    .payload_t ( rsp_chan_t )
  ) u_rob_store (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .alloc_valid_i ( alloc_valid   ),
    .alloc_idx_i   ( ax_rob_idx_o  ),
    .rsp_valid_i   ( rsp_valid_i   ),
    .rsp_ready_o   ( rsp_ready_o   ),
    .rsp_i         ( rsp_i         ),
    .rsp_rob_idx_i ( rsp_rob_idx_i ),
    .rsp_last_i    ( rsp_last_i    ),
    .head_idx_i    ( head_idx      ),
    .free_i        ( free          ),
    .head_valid_o  ( head_valid    ),
    .head_beat_o   ( head_beat     )
  );

  rob_release u_rob_release (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .head_valid_i ( head_valid  ),
    .head_beat_i  ( head_beat   ),
    .head_idx_o   ( head_idx    ),
    .free_o       ( free        ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_ready_i  ( rsp_ready_i ),
    .rsp_o        ( rsp_o       )
  );

endmodule

//--- test/tb_rob_wrapper.sv
// Testbench for the response reorder buffer with a network model and an in-order scoreboard
`timescale 1ns/1ps
`include "rob_cfg.svh"

module tb_rob_wrapper
  import noc_pkg::*;
  import rob_pkg::*;
;

  localparam int N_LINES   = 20;
  localparam int LIMIT     = 40 * N_LINES + 200;
  localparam int STALL_AT  = 20;
  localparam int STALL_LEN = 30;

  logic      clk_i = 1'b0;
  logic      reset_i = 1'b1;
  logic      ax_valid_i, ax_ready_o, ax_valid_o, ax_ready_i;
  ax_len_t   ax_len_i;
  ax_id_t    ax_id_i;
  dest_t     ax_dest_i;
  rob_idx_t  ax_rob_idx_o;
  logic      rsp_valid_i, rsp_ready_o, rsp_last_i;
  rsp_chan_t rsp_i;
  rob_idx_t  rsp_rob_idx_i;
  logic      rsp_valid_o, rsp_ready_i;
  rsp_chan_t rsp_o;

  logic [31:0] stim_mem [0:N_LINES*5-1];
  int          req_len [N_LINES];
  int          rank_line [N_LINES];
  bit          acc_flag [N_LINES];
  rob_idx_t    acc_idx [N_LINES];
  rsp_chan_t   exp_q [$];
  int          acc_beats = 0;
  int          out_beats = 0;
  int          total_beats = 0;
  int          cycle_cnt = 0;
  bit          saw_block = 0;
  bit          stall_random = 0;
  bit          hold_pending = 0;
  rsp_chan_t   held_beat;

  rob_wrapper u_rob_wrapper (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .ax_valid_i    ( ax_valid_i    ),
    .ax_ready_o    ( ax_ready_o    ),
    .ax_len_i      ( ax_len_i      ),
    .ax_id_i       ( ax_id_i       ),
    .ax_dest_i     ( ax_dest_i     ),
    .ax_valid_o    ( ax_valid_o    ),
    .ax_ready_i    ( ax_ready_i    ),
    .ax_rob_idx_o  ( ax_rob_idx_o  ),
    .rsp_valid_i   ( rsp_valid_i   ),
    .rsp_ready_o   ( rsp_ready_o   ),
    .rsp_i         ( rsp_i         ),
    .rsp_rob_idx_i ( rsp_rob_idx_i ),
    .rsp_last_i    ( rsp_last_i    ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .rsp_ready_i   ( rsp_ready_i   ),
    .rsp_o         ( rsp_o         )
  );

  always #50 clk_i = ~clk_i;

  task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
    if (got !== exp) begin
      $display("FAIL %0t %s: got %h expected %h", $time, msg, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // Run limit scales with the stimulus length
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > LIMIT) begin
      $display("timeout, output beats missing");
      $display("tests failed");
      $fatal(1, "run did not complete");
    end
  end

  // Random gaps on the network request side
  always @(posedge clk_i) begin
    if (!reset_i) begin
      ax_ready_i <= ($urandom % 4) != 0;
    end
    if (stall_random) begin
      rsp_ready_i <= ($urandom % 3) != 0;
    end
  end

  // Monitor samples mid-cycle, where all outputs have settled
  always @(negedge clk_i) begin
    int free_model;
    if (!reset_i) begin
      free_model = `ROB_SIZE - acc_beats + out_beats + (rsp_valid_o ? 1 : 0);
      if (ax_valid_i) begin
        compare_value(ax_valid_o, free_model >= int'(ax_len_i) + 1,
                      "ax_valid_o against free slots");
        compare_value(ax_ready_o, ax_ready_i && (free_model >= int'(ax_len_i) + 1),
                      "ax_ready_o against free slots");
        if (ax_ready_i && !ax_ready_o) begin
          saw_block = 1;
        end
        if (ax_ready_o) begin
          acc_beats += int'(ax_len_i) + 1;
        end
      end
      if (hold_pending) begin
        compare_value(rsp_valid_o, 1'b1, "rsp_valid_o dropped while stalled");
        compare_value(rsp_o, held_beat, "rsp_o changed while stalled");
      end
      hold_pending = 0;
      if (rsp_valid_o) begin
        if (rsp_ready_i) begin
          if (out_beats >= total_beats) begin
            compare_value(out_beats, total_beats - 1, "extra output beat");
          end
          compare_value(rsp_o, exp_q[out_beats], "output beat");
          out_beats++;
        end else begin
          hold_pending = 1;
          held_beat = rsp_o;
        end
      end
    end
  end

  // Request side issues one request after another in file order
  initial begin
    int exp_tail;
    bit accepted;
    exp_tail = 0;
    @(negedge reset_i);
    // Idle for one cycle after reset
    @(posedge clk_i);
    for (int i = 0; i < N_LINES; i++) begin
      ax_valid_i <= 1'b1;
      ax_id_i    <= ax_id_t'(stim_mem[i*5]);
      ax_len_i   <= ax_len_t'(stim_mem[i*5+1]);
      ax_dest_i  <= dest_t'(stim_mem[i*5+2]);
      accepted = 0;
      while (!accepted) begin
        @(negedge clk_i);
        if (ax_ready_o) begin
          compare_value(ax_valid_o, 1'b1, "ax_valid_o on accept");
          compare_value(ax_rob_idx_o, exp_tail, "base slot index");
          acc_idx[i] = ax_rob_idx_o;
          exp_tail = (exp_tail + req_len[i] + 1) % `ROB_SIZE;
          accepted = 1;
        end
      end
      @(posedge clk_i);
      acc_flag[i] = 1;
    end
    ax_valid_i <= 1'b0;
  end

  // Network returns whole bursts in rank order
  initial begin
    int i;
    @(negedge reset_i);
    for (int r = 0; r < N_LINES; r++) begin
      i = rank_line[r];
      wait (acc_flag[i]);
      for (int b = 0; b <= req_len[i]; b++) begin
        @(posedge clk_i);
        rsp_valid_i   <= 1'b1;
        rsp_i         <= '{id: ax_id_t'(stim_mem[i*5]), data: stim_mem[i*5+3] + b,
                           last: (b == req_len[i])};
        rsp_rob_idx_i <= acc_idx[i];
        rsp_last_i    <= (b == req_len[i]);
        @(negedge clk_i);
        compare_value(rsp_ready_o, 1'b1, "rsp_ready_o for reserved slot");
      end
      @(posedge clk_i);
      rsp_valid_i <= 1'b0;
    end
  end

  // Output ready held high, then held low to fill the buffer, then random stalls
  initial begin
    @(negedge reset_i);
    rsp_ready_i <= 1'b1;
    wait (out_beats >= STALL_AT);
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
    repeat (STALL_LEN) @(posedge clk_i);
    stall_random <= 1'b1;
  end

  initial begin
    void'($urandom(99527));
    ax_valid_i    = 1'b0;
    ax_ready_i    = 1'b0;
    ax_len_i      = '0;
    ax_id_i       = '0;
    ax_dest_i     = '0;
    rsp_valid_i   = 1'b0;
    rsp_i         = '0;
    rsp_rob_idx_i = '0;
    rsp_last_i    = 1'b0;
    rsp_ready_i   = 1'b0;
    $readmemh("test/rob_stimulus.txt", stim_mem);
    // Expected output is every beat in request order
    for (int i = 0; i < N_LINES; i++) begin
      req_len[i] = int'(stim_mem[i*5+1]);
      rank_line[stim_mem[i*5+4]] = i;
      for (int b = 0; b <= req_len[i]; b++) begin
        exp_q.push_back('{id: ax_id_t'(stim_mem[i*5]), data: stim_mem[i*5+3] + b,
                          last: (b == req_len[i])});
      end
      total_beats += req_len[i] + 1;
    end
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    compare_value(ax_valid_o, 1'b0, "ax_valid_o after reset");
    compare_value(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    wait (out_beats == total_beats);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    compare_value(rsp_valid_o, 1'b0, "rsp_valid_o after last beat");
    compare_value(saw_block, 1'b1, "ax_ready_o never fell on a full buffer");
    $display("all tests passed");
    $finish;
  end

endmodule

//--- test/rob_stimulus.txt
// Columns in hex: id, len (beats minus one), dest, data base, return rank
// Groups of up to 16 beats, each returned out of order by the network
1 3 0 00001000 3
2 3 1 00002000 2
3 3 2 00003000 1
4 3 3 00004000 0
5 0 0 00005000 9
6 3 1 00006000 7
7 0 2 00007000 8
8 3 3 00008000 5
9 0 0 00009000 6
a 3 1 0000a000 4
b 3 2 0000b000 d
c 3 3 0000c000 c
d 3 0 0000d000 b
e 3 1 0000e000 a
f 1 2 0000f000 10
0 2 3 00010000 e
1 0 0 00011000 13
2 3 1 00012000 f
3 1 2 00013000 12
4 2 3 00014000 11

//--- all.f
+incdir+source
source/noc_pkg.sv
source/rob_pkg.sv
source/rob_alloc.sv
source/rob_store.sv
source/rob_release.sv
source/rob_wrapper.sv
test/tb_rob_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob_wrapper
SEED      ?= 99527
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir

SRCS := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
